// ==== list.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipe_top.sv
tests/pipe_tb.sv

// ==== Bender.yml ====
package:
  name: pipe

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/regfile.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/pipe_top.sv
  - target: test
    files:
      - tests/pipe_tb.sv

// ==== tests/pipe_tb.sv ====
`timescale 1ns/1ns

module pipe_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM     = 40;
  localparam int DRAIN_MAX    = 8;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  logic [INSTR_W-1:0]    instr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  // Stimulus table, one row per issue slot
  int                 tbl_test[$];
  logic               tbl_strobe[$];
  logic [INSTR_W-1:0] tbl_word[$];
  logic [XLEN-1:0]    tbl_exp[$];

  // Reference model state
  logic [XLEN-1:0] mregs [REG_NUM];
  logic [XLEN-1:0] mmem [DMEM_DEPTH];
  logic [XLEN-1:0] mpc;

  // Expected writebacks in issue order
  logic [REG_ADDR_W-1:0] exp_rd[$];
  logic [XLEN-1:0]       exp_data[$];
  int                    exp_cyc[$];

  int                    cyc = 0;
  int                    limit = 0;
  int                    errors = 0;
  int                    seen = 0;
  int                    err_mark = 0;
  int                    seen_mark = 0;
  logic [31:0]           rand_state;
  logic [REG_ADDR_W-1:0] e_rd;
  logic [XLEN-1:0]       e_data;
  int                    e_cyc;

  pipe_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    wait (limit > 0);
    wait (cyc >= limit);
    $display("timeout after %0d cycles, the run did not complete", cyc);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  function automatic logic [XLEN-1:0] sext(input logic [IMM_W-1:0] imm);
    return {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

  function automatic logic [INSTR_W-1:0] encode(input op_t op, input int rd, input int ra,
                                                input int rb, input int imm);
    logic [INSTR_W-1:0] w;
    w = '0;
    w[OP_LSB +: OP_W]       = op;
    w[RD_LSB +: REG_ADDR_W] = rd[REG_ADDR_W-1:0];
    w[RA_LSB +: REG_ADDR_W] = ra[REG_ADDR_W-1:0];
    w[RB_LSB +: REG_ADDR_W] = rb[REG_ADDR_W-1:0];
    w[IMM_W-1:0]            = imm[IMM_W-1:0];
    return w;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0: return "alu ops with ex forwarding";
      1: return "mem, wb and stored forwarding";
      2: return "store and load";
      3: return "link address";
      4: return "register zero";
      default: return "random alu stream";
    endcase
  endfunction

  task automatic add_row(input int test, input logic strobe, input op_t op, input int rd,
                         input int ra, input int rb, input int imm, input logic [XLEN-1:0] exp);
    tbl_test.push_back(test);
    tbl_strobe.push_back(strobe);
    tbl_word.push_back(encode(op, rd, ra, rb, imm));
    tbl_exp.push_back(exp);
  endtask

  task automatic bubble(input int test);
    add_row(test, 1'b0, NOP, 0, 0, 0, 0, '0);
  endtask

  task automatic build_table();
    // Back-to-back dependencies go through the EX path
    add_row(0, 1'b1, ADDI, 1, 0, 0, 5, 32'h5);
    add_row(0, 1'b1, ADDI, 2, 1, 0, 7, 32'hc);
    add_row(0, 1'b1, ADD, 3, 1, 2, 0, 32'h11);
    add_row(0, 1'b1, SUB, 4, 3, 1, 0, 32'hc);
    add_row(0, 1'b1, MUL, 5, 4, 3, 0, 32'hcc);
    add_row(0, 1'b1, ADDI, 6, 5, 0, -4, 32'hc8);
    add_row(0, 1'b1, SUB, 7, 1, 2, 0, 32'hffff_fff9);
    // Distances 2, 3 and 4
    add_row(1, 1'b1, ADDI, 8, 0, 0, 100, 32'h64);
    add_row(1, 1'b1, ADDI, 9, 0, 0, 20, 32'h14);
    add_row(1, 1'b1, ADD, 10, 8, 0, 0, 32'h64);
    add_row(1, 1'b1, SUB, 11, 8, 9, 0, 32'h50);
    add_row(1, 1'b1, MUL, 12, 8, 9, 0, 32'h7d0);
    bubble(1);
    bubble(1);
    add_row(1, 1'b1, ADD, 13, 12, 11, 0, 32'h820);
    bubble(1);
    bubble(1);
    bubble(1);
    add_row(1, 1'b1, ADD, 14, 13, 10, 0, 32'h884);
    // Store, load, and a use two slots behind the load
    add_row(2, 1'b1, ADDI, 15, 0, 0, 85, 32'h55);
    add_row(2, 1'b1, ST, 0, 0, 15, 8, '0);
    add_row(2, 1'b1, ADDI, 16, 0, 0, 4, 32'h4);
    add_row(2, 1'b1, LD, 17, 16, 0, 4, 32'h55);
    add_row(2, 1'b1, NOP, 0, 0, 0, 0, '0);
    add_row(2, 1'b1, ADD, 18, 17, 15, 0, 32'haa);
    // Address 64 wraps to word 0
    add_row(2, 1'b1, ST, 0, 16, 18, 60, '0);
    add_row(2, 1'b1, LD, 19, 0, 0, 0, 32'haa);
    // Bubbles leave pc alone
    bubble(3);
    add_row(3, 1'b1, LINK, 20, 0, 0, 0, 32'h17);
    bubble(3);
    bubble(3);
    add_row(3, 1'b1, LINK, 21, 0, 0, 0, 32'h18);
    add_row(3, 1'b1, ADD, 22, 21, 20, 0, 32'h2f);
    add_row(4, 1'b1, ADDI, 0, 0, 0, 33, '0);
    add_row(4, 1'b1, ADD, 0, 1, 2, 0, '0);
    add_row(4, 1'b1, ADD, 23, 0, 0, 0, 32'h0);
    add_row(4, 1'b1, LINK, 0, 0, 0, 0, '0);
    add_row(4, 1'b1, ADDI, 24, 0, 0, 1, 32'h1);
  endtask

  // Drive one slot and step the reference model
  task automatic issue(input logic strobe, input logic [INSTR_W-1:0] word,
                       output logic expect_wb, output logic [XLEN-1:0] val);
    op_t             op;
    int              rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] addr;
    op   = op_t'(word[OP_LSB +: OP_W]);
    rd   = word[RD_LSB +: REG_ADDR_W];
    a    = mregs[word[RA_LSB +: REG_ADDR_W]];
    b    = mregs[word[RB_LSB +: REG_ADDR_W]];
    addr = a + sext(word[IMM_W-1:0]);
    expect_wb = 1'b0;
    val       = '0;
    @(posedge clk);
    #1;
    instr_valid = strobe;
    instr       = word;
    if (strobe) begin
      case (op)
        ADD:  val = a + b;
        SUB:  val = a - b;
        MUL:  val = a * b;
        ADDI: val = addr;
        LD:   val = mmem[addr[DMEM_ADDR_W-1:0]];
        ST:   mmem[addr[DMEM_ADDR_W-1:0]] = b;
        LINK: val = mpc + 1;
        default: ;
      endcase
      expect_wb = (op inside {ADD, SUB, MUL, ADDI, LD, LINK}) && (rd != 0);
      mpc = mpc + 1;
      if (expect_wb) begin
        mregs[rd] = val;
        exp_rd.push_back(rd[REG_ADDR_W-1:0]);
        exp_data.push_back(val);
        // Sampled at the next edge
        exp_cyc.push_back(cyc + 1);
      end
    end
  endtask

  task automatic finish_test(input int id);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    instr       = '0;
    while (exp_rd.size() != 0 && waited < DRAIN_MAX) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_rd.size() != 0) begin
      $display("test %0d: %0d expected writebacks never arrived", id, exp_rd.size());
      errors += exp_rd.size();
      exp_rd.delete();
      exp_data.delete();
      exp_cyc.delete();
    end
    $display("test %0d %s: %0d writebacks checked, %0d errors", id, test_name(id),
             seen - seen_mark, errors - err_mark);
    seen_mark = seen;
    err_mark  = errors;
  endtask

  // Writeback checker, samples at the rising edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n && wb_valid) begin
      if (exp_rd.size() == 0) begin
        errors++;
        $display("writeback to r%0d with data %h arrived while none was expected",
                 wb_rd, wb_data);
      end else begin
        e_rd   = exp_rd.pop_front();
        e_data = exp_data.pop_front();
        e_cyc  = exp_cyc.pop_front();
        seen++;
        if (wb_rd !== e_rd) begin
          errors++;
          $display("mismatch wb_rd: got %h, expected %h", wb_rd, e_rd);
        end
        if (wb_data !== e_data) begin
          errors++;
          $display("mismatch wb_data: got %h, expected %h", wb_data, e_data);
        end
        if (cyc - e_cyc != 4) begin
          errors++;
          $display("writeback to r%0d came %0d cycles after issue instead of 4",
                   wb_rd, cyc - e_cyc);
        end
      end
    end
  end

  initial begin
    int                 i;
    int                 cur;
    logic               expect_wb;
    logic [XLEN-1:0]    val;
    logic [31:0]        r;
    op_t                op;
    logic [INSTR_W-1:0] word;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (i = 0; i < REG_NUM; i++) begin
      mregs[i] = '0;
    end
    for (i = 0; i < DMEM_DEPTH; i++) begin
      mmem[i] = '0;
    end
    mpc        = '0;
    rand_state = 32'd17814;
    build_table();
    limit = RESET_CYCLES + tbl_word.size() + N_RANDOM + 50;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    cur = tbl_test[0];
    for (i = 0; i < tbl_word.size(); i++) begin
      if (tbl_test[i] != cur) begin
        finish_test(cur);
        cur = tbl_test[i];
      end
      issue(tbl_strobe[i], tbl_word[i], expect_wb, val);
      if (expect_wb && val !== tbl_exp[i]) begin
        errors++;
        $display("table row %0d expects %h but the reference model gives %h",
                 i, tbl_exp[i], val);
      end
    end
    finish_test(cur);

    // Registers drawn from r0..r7 so dependencies are frequent
    for (i = 0; i < N_RANDOM; i++) begin
      r = next_rand();
      case (r % 4)
        0: op = ADD;
        1: op = SUB;
        2: op = MUL;
        default: op = ADDI;
      endcase
      word = encode(op, next_rand() % 8, next_rand() % 8, next_rand() % 8, next_rand());
      issue(1'b1, word, expect_wb, val);
    end
    finish_test(5);

    $display("%0d writebacks checked over 6 tests, %0d errors", seen, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== logic/pipe_top.sv ====
`timescale 1ns/1ns

module pipe_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            instr_valid,
  input  logic [isa_pkg::INSTR_W-1:0]     instr,
  output logic                            wb_valid,
  output logic [pipe_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [pipe_pkg::XLEN-1:0]       wb_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Decode to execute
  logic                  d_valid;
  op_t                   d_op;
  logic [REG_ADDR_W-1:0] d_rd;
  logic                  d_we;
  logic [XLEN-1:0]       d_a;
  logic [XLEN-1:0]       d_b;
  logic [XLEN-1:0]       d_store;
  logic [XLEN-1:0]       d_link;

  // Execute to memory, and the EX bypass
  logic                  ex_valid;
  op_t                   ex_op;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic                  ex_we;
  logic [XLEN-1:0]       ex_result;
  logic [XLEN-1:0]       ex_store;

  // MEM and WB bypass back into decode
  logic [REG_ADDR_W-1:0] mem_rd;
  logic                  mem_we;
  logic [XLEN-1:0]       mem_result;
  logic                  wb_we;

  decode_stage i_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ex_rd       (ex_rd),
    .ex_we       (ex_we),
    .mem_rd      (mem_rd),
    .mem_we      (mem_we),
    .wb_rd       (wb_rd),
    .wb_we       (wb_we),
    .ex_result   (ex_result),
    .mem_result  (mem_result),
    .wb_data     (wb_data),
    .d_valid     (d_valid),
    .d_op        (d_op),
    .d_rd        (d_rd),
    .d_we        (d_we),
    .d_a         (d_a),
    .d_b         (d_b),
    .d_store     (d_store),
    .d_link      (d_link)
  );

  execute_stage i_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .d_valid   (d_valid),
    .d_op      (d_op),
    .d_rd      (d_rd),
    .d_we      (d_we),
    .d_a       (d_a),
    .d_b       (d_b),
    .d_store   (d_store),
    .d_link    (d_link),
    .ex_valid  (ex_valid),
    .ex_op     (ex_op),
    .ex_rd     (ex_rd),
    .ex_we     (ex_we),
    .ex_result (ex_result),
    .ex_store  (ex_store)
  );

  memory_stage i_memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid   (ex_valid),
    .ex_op      (ex_op),
    .ex_rd      (ex_rd),
    .ex_we      (ex_we),
    .ex_result  (ex_result),
    .ex_store   (ex_store),
    .mem_rd     (mem_rd),
    .mem_we     (mem_we),
    .mem_result (mem_result),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_we      (wb_we),
    .wb_data    (wb_data)
  );

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            ex_valid,
  input  isa_pkg::op_t                    ex_op,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] ex_rd,
  input  logic                            ex_we,
  input  logic [pipe_pkg::XLEN-1:0]       ex_result,
  input  logic [pipe_pkg::XLEN-1:0]       ex_store,
  output logic [pipe_pkg::REG_ADDR_W-1:0] mem_rd,
  output logic                            mem_we,
  output logic [pipe_pkg::XLEN-1:0]       mem_result,
  output logic                            wb_valid,
  output logic [pipe_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic                            wb_we,
  output logic [pipe_pkg::XLEN-1:0]       wb_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic                   m_valid;
  op_t                    m_op;
  logic [XLEN-1:0]        m_alu;
  logic [XLEN-1:0]        m_store;
  logic [DMEM_ADDR_W-1:0] addr;
  logic                   wb_v;
  logic [XLEN-1:0]        dmem [DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      mem_we  <= 1'b0;
      wb_v    <= 1'b0;
      wb_we   <= 1'b0;
    end else begin
      m_valid <= ex_valid;
      mem_we  <= ex_we;
      wb_v    <= m_valid;
      wb_we   <= mem_we;
    end
  end

  always_ff @(posedge clk) begin
    m_op    <= ex_op;
    mem_rd  <= ex_rd;
    m_alu   <= ex_result;
    m_store <= ex_store;
    wb_rd   <= mem_rd;
    wb_data <= mem_result;
  end

  // Address wraps on the low bits of the ALU sum
  assign addr = m_alu[DMEM_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (m_valid && m_op == ST) begin
      dmem[addr] <= m_store;
    end
  end

  // Read is combinational, so a load forwards its data from this stage
  assign mem_result = (m_op == LD) ? dmem[addr] : m_alu;

  assign wb_valid = wb_v && wb_we;

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            d_valid,
  input  isa_pkg::op_t                    d_op,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] d_rd,
  input  logic                            d_we,
  input  logic [pipe_pkg::XLEN-1:0]       d_a,
  input  logic [pipe_pkg::XLEN-1:0]       d_b,
  input  logic [pipe_pkg::XLEN-1:0]       d_store,
  input  logic [pipe_pkg::XLEN-1:0]       d_link,
  output logic                            ex_valid,
  output isa_pkg::op_t                    ex_op,
  output logic [pipe_pkg::REG_ADDR_W-1:0] ex_rd,
  output logic                            ex_we,
  output logic [pipe_pkg::XLEN-1:0]       ex_result,
  output logic [pipe_pkg::XLEN-1:0]       ex_store
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  logic [XLEN-1:0] link_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
    end else begin
      ex_valid <= d_valid;
      ex_we    <= d_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_op    <= d_op;
    ex_rd    <= d_rd;
    a_q      <= d_a;
    b_q      <= d_b;
    ex_store <= d_store;
    link_q   <= d_link;
  end

  // Loads and stores reuse the adder for the address
  always_comb begin
    case (ex_op)
      ADD, ADDI, LD, ST: ex_result = a_q + b_q;
      SUB:               ex_result = a_q - b_q;
      MUL:               ex_result = a_q * b_q;  // low word only
      LINK:              ex_result = link_q;
      default:           ex_result = '0;
    endcase
  end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            instr_valid,
  input  logic [isa_pkg::INSTR_W-1:0]     instr,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] ex_rd,
  input  logic                            ex_we,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] mem_rd,
  input  logic                            mem_we,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic                            wb_we,
  input  logic [pipe_pkg::XLEN-1:0]       ex_result,
  input  logic [pipe_pkg::XLEN-1:0]       mem_result,
  input  logic [pipe_pkg::XLEN-1:0]       wb_data,
  output logic                            d_valid,
  output isa_pkg::op_t                    d_op,
  output logic [pipe_pkg::REG_ADDR_W-1:0] d_rd,
  output logic                            d_we,
  output logic [pipe_pkg::XLEN-1:0]       d_a,
  output logic [pipe_pkg::XLEN-1:0]       d_b,
  output logic [pipe_pkg::XLEN-1:0]       d_store,
  output logic [pipe_pkg::XLEN-1:0]       d_link
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [INSTR_W-1:0]    instr_q;
  logic [XLEN-1:0]       pc;
  logic [REG_ADDR_W-1:0] ra;
  logic [REG_ADDR_W-1:0] rb;
  logic [IMM_W-1:0]      imm;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic                  use_a;
  logic                  use_b;
  logic                  use_imm;
  logic                  writes_rd;
  logic [1:0]            ex_bp;
  logic [1:0]            mem_bp;
  logic [1:0]            wb_bp;

  // pc counts accepted strobes, bubbles leave it alone
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_valid <= 1'b0;
      pc      <= '0;
    end else begin
      d_valid <= instr_valid;
      if (instr_valid) begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
    end
  end

  assign d_op = op_t'(instr_q[OP_LSB +: OP_W]);
  assign d_rd = instr_q[RD_LSB +: REG_ADDR_W];
  assign ra   = instr_q[RA_LSB +: REG_ADDR_W];
  assign rb   = instr_q[RB_LSB +: REG_ADDR_W];
  assign imm  = instr_q[IMM_W-1:0];

  assign use_a     = d_op inside {ADD, SUB, MUL, ADDI, LD, ST};
  assign use_b     = d_op inside {ADD, SUB, MUL, ST};
  assign use_imm   = d_op inside {ADDI, LD, ST};
  assign writes_rd = d_op inside {ADD, SUB, MUL, ADDI, LD, LINK};

  // r0 never gets a write enable, so it never forwards either
  assign d_we = d_valid && writes_rd && (d_rd != '0);

  // Select bits are {ra hit, rb hit}
  assign ex_bp  = {ex_we && (ra == ex_rd), ex_we && (rb == ex_rd)};
  assign mem_bp = {mem_we && (ra == mem_rd), mem_we && (rb == mem_rd)};
  assign wb_bp  = {wb_we && (ra == wb_rd), wb_we && (rb == wb_rd)};

  regfile i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .ra         (ra),
    .rb         (rb),
    .ex_bp      (ex_bp),
    .mem_bp     (mem_bp),
    .wb_bp      (wb_bp),
    .ex_result  (ex_result),
    .mem_result (mem_result),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b)
  );

  assign d_a     = rdata_a;
  assign d_b     = use_imm ? {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm} : rdata_b;
  assign d_store = rdata_b;

  // Counter has already stepped past this instruction, so it reads pc+1
  assign d_link = pc;

  // Load data only exists from Memory on, a load-use at distance one is illegal
  a_no_load_use: assert property (@(posedge clk) disable iff (!rst_n)
    (d_valid && d_op == LD) |=>
      !(d_valid && ex_we && ((use_a && ra == ex_rd) || (use_b && rb == ex_rd))));

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ns

module regfile (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] ra,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] rb,
  input  logic [1:0]                      ex_bp,
  input  logic [1:0]                      mem_bp,
  input  logic [1:0]                      wb_bp,
  input  logic [pipe_pkg::XLEN-1:0]       ex_result,
  input  logic [pipe_pkg::XLEN-1:0]       mem_result,
  input  logic                            wb_we,
  input  logic [pipe_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [pipe_pkg::XLEN-1:0]       wb_data,
  output logic [pipe_pkg::XLEN-1:0]       rdata_a,
  output logic [pipe_pkg::XLEN-1:0]       rdata_b
);
  import pipe_pkg::*;

  logic [XLEN-1:0] regs [REG_NUM];

  // Newest producer wins: EX, then MEM, then WB, then storage
  function automatic logic [XLEN-1:0] fwd_pick(
    input logic            ex_hit,
    input logic            mem_hit,
    input logic            wb_hit,
    input logic [XLEN-1:0] ex_val,
    input logic [XLEN-1:0] mem_val,
    input logic [XLEN-1:0] wb_val,
    input logic [XLEN-1:0] stored
  );
    if (ex_hit) begin
      return ex_val;
    end else if (mem_hit) begin
      return mem_val;
    end else if (wb_hit) begin
      return wb_val;
    end
    return stored;
  endfunction

  // Single write port, fed from the writeback register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Upper select bit is port a, lower is port b
  assign rdata_a = fwd_pick(ex_bp[1], mem_bp[1], wb_bp[1],
                            ex_result, mem_result, wb_data, regs[ra]);
  assign rdata_b = fwd_pick(ex_bp[0], mem_bp[0], wb_bp[0],
                            ex_result, mem_result, wb_data, regs[rb]);

  // Decode drops the enable for rd zero, so r0 stays zero
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_we |-> (wb_rd != '0));

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

  // Data word width
  localparam int XLEN = 32;

  // Register file size
  localparam int REG_NUM    = 32;
  localparam int REG_ADDR_W = 5;

  // Data memory, word addressed by the low address bits
  localparam int DMEM_DEPTH  = 64;
  localparam int DMEM_ADDR_W = 6;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  // Instruction word layout, MSB first
  //   [31:30] reserved
  //   [29:26] opcode
  //   [25:21] rd
  //   [20:16] ra
  //   [15:11] rb
  //   [10:0]  imm, sign-extended
  localparam int INSTR_W = 32;

  localparam int OP_W   = 4;
  localparam int OP_LSB = 26;

  // Register fields are 5 bits wide each
  localparam int RD_LSB = 21;
  localparam int RA_LSB = 16;
  localparam int RB_LSB = 11;

  // Immediate sits in the low bits
  localparam int IMM_W = 11;

  // MUL keeps only the low word of the product
  // LINK writes pc+1 into rd
  typedef enum logic [OP_W-1:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    MUL  = 4'd3,
    ADDI = 4'd4,
    LD   = 4'd5,
    ST   = 4'd6,
    LINK = 4'd7
  } op_t;

endpackage
